//--- rtl/fsk_defs.svh
`ifndef FSK_DEFS_SVH
`define FSK_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock and tones, scaled down for simulation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FSK_CLOCK_HZ        1000000
`define FSK_F0_HZ           9000        // space
`define FSK_F1_HZ           11000       // mark
`define FSK_DEVIATION_PCT   10

// nominal half periods in clock cycles
`define FSK_F0_HALF         (`FSK_CLOCK_HZ / (2 * `FSK_F0_HZ))
`define FSK_F1_HALF         (`FSK_CLOCK_HZ / (2 * `FSK_F1_HZ))

// allowed deviation of one half period
`define FSK_F0_TOL          ((`FSK_F0_HALF * `FSK_DEVIATION_PCT) / 100)
`define FSK_F1_TOL          ((`FSK_F1_HALF * `FSK_DEVIATION_PCT) / 100)

// bit timing
`define FSK_BIT_CYCLES      1000
`define FSK_MIN_OCCUPANCY   500         // band 0 plus band 1 cycles per window

`endif

//--- rtl/fsk_pkg.sv
package fsk_pkg;

    // length of one tone half period in clock cycles
    typedef logic [15:0] half_period_t;

    // cycles credited to one band inside a bit window
    typedef logic [15:0] occupancy_t;

    // position inside the current bit window
    typedef logic [15:0] window_count_t;

    typedef logic [7:0] byte_t;

    typedef enum logic [1:0]
    {
        IDLE,
        DATA,
        STOP
    } deframer_state_e;

endpackage

//--- rtl/edge_sync.sv
`timescale 1ns/100ps

module edge_sync
(
    input  logic clock,
    input  logic rst_n,
    input  logic tone_in,
    output logic tone_edge
);

    logic sync_meta;    // first stage, may go metastable
    logic sync_level;
    logic prev_level;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two-flop synchronizer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_meta  <= 1'b0;
            sync_level <= 1'b0;
        end
        else
        begin
            sync_meta  <= tone_in;
            sync_level <= sync_meta;
        end
    end

    // previous synchronized level for the edge compare
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            prev_level <= 1'b0;
        end
        else
        begin
            prev_level <= sync_level;
        end
    end

    assign tone_edge = sync_level ^ prev_level;     // rising or falling

endmodule

//--- rtl/tone_analyzer.sv
`timescale 1ns/100ps
`include "fsk_defs.svh"

module tone_analyzer
(
    input  logic                clock,
    input  logic                rst_n,
    input  logic                tone_edge,
    input  logic                window_end,
    output fsk_pkg::occupancy_t occupancy_f0,
    output fsk_pkg::occupancy_t occupancy_f1
);

    fsk_pkg::half_period_t half_count;     // cycles since the last edge
    fsk_pkg::occupancy_t   credit_len;
    logic                  in_band_f0;
    logic                  in_band_f1;
    logic                  credit_f0;
    logic                  credit_f1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // half period counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            half_count <= '0;
        end
        else if (tone_edge)
        begin
            half_count <= fsk_pkg::half_period_t'(1);   // edge cycle counts as the first
        end
        else if (half_count != '1)
        begin
            half_count <= half_count + 1'b1;            // holds at max without edges
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // band classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        in_band_f0 = (half_count >= (`FSK_F0_HALF - `FSK_F0_TOL)) &&
                     (half_count <= (`FSK_F0_HALF + `FSK_F0_TOL));
        in_band_f1 = (half_count >= (`FSK_F1_HALF - `FSK_F1_TOL)) &&
                     (half_count <= (`FSK_F1_HALF + `FSK_F1_TOL));
        credit_f0  = tone_edge && in_band_f0;
        credit_f1  = tone_edge && in_band_f1;
        credit_len = half_count;
    end

    // occupancy accumulators reloaded at each window end
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            occupancy_f0 <= '0;
            occupancy_f1 <= '0;
        end
        else if (window_end)
        begin
            // the slicer samples the old totals in this cycle
            occupancy_f0 <= credit_f0 ? credit_len : '0;
            occupancy_f1 <= credit_f1 ? credit_len : '0;
        end
        else
        begin
            if (credit_f0)
            begin
                occupancy_f0 <= occupancy_f0 + credit_len;
            end
            if (credit_f1)
            begin
                occupancy_f1 <= occupancy_f1 + credit_len;
            end
        end
    end

    // an edge adds at most one widest in-band half period and nothing after a stall
    property credit_bounded_p;
        @(posedge clock) disable iff (!rst_n)
        tone_edge |=>
            ($past(window_end) ?
                (occupancy_f0 + occupancy_f1) :
                (occupancy_f0 + occupancy_f1) - ($past(occupancy_f0) + $past(occupancy_f1)))
            <= (($past(half_count) == '1) ? 0 : (`FSK_F0_HALF + `FSK_F0_TOL));
    endproperty

    credit_bounded_a: assert property (credit_bounded_p)
        else $error("tone_analyzer credit out of range");

endmodule

//--- rtl/bit_slicer.sv
`timescale 1ns/100ps
`include "fsk_defs.svh"

module bit_slicer
(
    input  logic                clock,
    input  logic                rst_n,
    input  fsk_pkg::occupancy_t occupancy_f0,
    input  fsk_pkg::occupancy_t occupancy_f1,
    output logic                window_end,
    output logic                bit_strobe,
    output logic                bit_value,
    output logic                carrier
);

    fsk_pkg::window_count_t window_count;
    logic [16:0]            occ_sum;        // one bit wider, no overflow

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // free running bit window
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign window_end = (window_count == fsk_pkg::window_count_t'(`FSK_BIT_CYCLES - 1));

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            window_count <= '0;
        end
        else if (window_end)
        begin
            window_count <= '0;
        end
        else
        begin
            window_count <= window_count + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign occ_sum = {1'b0, occupancy_f0} + {1'b0, occupancy_f1};

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_strobe <= 1'b0;
            bit_value  <= 1'b0;
            carrier    <= 1'b0;
        end
        else
        begin
            bit_strobe <= window_end;               // one cycle after the window closes
            if (window_end)
            begin
                carrier   <= (occ_sum >= `FSK_MIN_OCCUPANCY);
                bit_value <= (occupancy_f1 > occupancy_f0);     // ties go to space
            end
        end
    end

    // windows are far longer than one cycle
    bit_strobe_single_a: assert property (@(posedge clock) disable iff (!rst_n)
        bit_strobe |=> !bit_strobe)
        else $error("bit_slicer bit_strobe held for two cycles");

endmodule

//--- rtl/byte_deframer.sv
`timescale 1ns/100ps

module byte_deframer
(
    input  logic           clock,
    input  logic           rst_n,
    input  logic           bit_strobe,
    input  logic           bit_value,
    input  logic           carrier,
    output logic           byte_strobe,
    output fsk_pkg::byte_t byte_data,
    output logic           framing_error
);

    fsk_pkg::deframer_state_e state;
    logic [2:0]               bit_index;
    fsk_pkg::byte_t           shift_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // framing FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= fsk_pkg::IDLE;
            bit_index     <= '0;
            byte_strobe   <= 1'b0;
            byte_data     <= '0;
            framing_error <= 1'b0;
        end
        else
        begin
            byte_strobe   <= 1'b0;
            framing_error <= 1'b0;
            if (bit_strobe)
            begin
                case (state)
                    fsk_pkg::IDLE:
                    begin
                        if (carrier && !bit_value)      // start bit
                        begin
                            state     <= fsk_pkg::DATA;
                            bit_index <= '0;
                        end
                    end
                    fsk_pkg::DATA:
                    begin
                        if (!carrier)
                        begin
                            framing_error <= 1'b1;      // carrier lost mid frame
                            state         <= fsk_pkg::IDLE;
                        end
                        else
                        begin
                            bit_index <= bit_index + 1'b1;
                            if (bit_index == 3'd7)
                            begin
                                state <= fsk_pkg::STOP;
                            end
                        end
                    end
                    fsk_pkg::STOP:
                    begin
                        if (carrier && bit_value)
                        begin
                            byte_strobe <= 1'b1;
                            byte_data   <= shift_reg;
                        end
                        else
                        begin
                            framing_error <= 1'b1;
                        end
                        state <= fsk_pkg::IDLE;
                    end
                    default:
                    begin
                        state <= fsk_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // data arrives LSB first, so shift in from the top
    always_ff @(posedge clock)
    begin
        if (bit_strobe && state == fsk_pkg::DATA)
        begin
            shift_reg <= {bit_value, shift_reg[7:1]};
        end
    end

    strobe_exclusive_a: assert property (@(posedge clock) disable iff (!rst_n)
        !(byte_strobe && framing_error))
        else $error("byte_deframer byte and error strobes together");

endmodule

//--- rtl/fsk_demod.sv
`timescale 1ns/100ps

module fsk_demod
(
    input  logic           clock,
    input  logic           rst_n,
    input  logic           tone_in,
    output logic           byte_strobe,
    output fsk_pkg::byte_t byte_data,
    output logic           framing_error
);

    logic                tone_edge;
    logic                window_end;
    fsk_pkg::occupancy_t occupancy_f0;
    fsk_pkg::occupancy_t occupancy_f1;
    logic                bit_strobe;
    logic                bit_value;
    logic                carrier;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    edge_sync i_edge_sync
    (
        .clock     (clock),
        .rst_n     (rst_n),
        .tone_in   (tone_in),
        .tone_edge (tone_edge)
    );

    tone_analyzer i_tone_analyzer
    (
        .clock        (clock),
        .rst_n        (rst_n),
        .tone_edge    (tone_edge),
        .window_end   (window_end),
        .occupancy_f0 (occupancy_f0),
        .occupancy_f1 (occupancy_f1)
    );

    bit_slicer i_bit_slicer
    (
        .clock        (clock),
        .rst_n        (rst_n),
        .occupancy_f0 (occupancy_f0),
        .occupancy_f1 (occupancy_f1),
        .window_end   (window_end),
        .bit_strobe   (bit_strobe),
        .bit_value    (bit_value),
        .carrier      (carrier)
    );

    byte_deframer i_byte_deframer
    (
        .clock         (clock),
        .rst_n         (rst_n),
        .bit_strobe    (bit_strobe),
        .bit_value     (bit_value),
        .carrier       (carrier),
        .byte_strobe   (byte_strobe),
        .byte_data     (byte_data),
        .framing_error (framing_error)
    );

endmodule

//--- tb/fsk_tone_gen.sv
`timescale 1ns/100ps
`include "fsk_defs.svh"

module fsk_tone_gen
(
    input  logic clock,
    input  logic rst_n,
    output logic tone_in
);

    int     symbols[$];     // half period per window, 0 holds the level
    integer seed;
    int     window_pos;     // follows the bit_slicer window counter
    int     half_len;
    int     half_left;
    logic   level;

    initial
    begin
        seed    = 27;
        level   = 1'b0;
        tone_in = 1'b0;
    end

    task add_symbol(input int half);
        symbols.push_back(half);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one symbol per window, jittered half periods
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            window_pos = 0;
            half_len   = 0;
            half_left  = 0;
        end
        else
        begin
            if (window_pos == 0)
            begin
                half_len = 0;                   // silence once the queue runs dry
                if (symbols.size() != 0)
                begin
                    half_len = symbols.pop_front();
                end
                half_left = 0;
            end
            if (half_len != 0)
            begin
                if (half_left == 0)
                begin
                    level     = ~level;
                    half_left = half_len + ($random(seed) % 3);    // +-2 cycles
                end
                half_left = half_left - 1;
            end
            tone_in <= level;
            window_pos = (window_pos == `FSK_BIT_CYCLES - 1) ? 0 : window_pos + 1;
        end
    end

endmodule

//--- tb/tb_fsk_demod.sv
`timescale 1ns/100ps
`include "fsk_defs.svh"

module tb_fsk_demod;

    localparam int OOB_HALF   = 70;                 // outside both bands
    localparam int WAIT_LIMIT = 20 * `FSK_BIT_CYCLES;

    logic           clock;
    logic           rst_n;
    logic           tone_in;
    logic           byte_strobe;
    fsk_pkg::byte_t byte_data;
    logic           framing_error;

    integer seed;
    int     error_count;
    int     cycle_count;        // rising edges since reset release
    int     total_windows;
    int     exp_value[$];       // byte value, -1 for a framing error
    string  exp_test[$];
    int     got_value;
    int     want_value;
    string  want_test;
    int     pending;
    int     wait_cycles;
    int     end_cycle;
    int     gap;
    int     i;

    fsk_tone_gen i_tone_gen
    (
        .clock   (clock),
        .rst_n   (rst_n),
        .tone_in (tone_in)
    );

    fsk_demod i_fsk_demod
    (
        .clock         (clock),
        .rst_n         (rst_n),
        .tone_in       (tone_in),
        .byte_strobe   (byte_strobe),
        .byte_data     (byte_data),
        .framing_error (framing_error)
    );

    always #5 clock = ~clock;

    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            cycle_count <= 0;
        end
        else
        begin
            cycle_count <= cycle_count + 1;
        end
    end

    function string event_text(input int value);
        if (value < 0)
        begin
            return "framing_error";
        end
        return $sformatf("byte 0x%02h", value[7:0]);
    endfunction

    task queue_symbol(input int half);
        i_tone_gen.add_symbol(half);
        total_windows++;
    endtask

    task add_expected(input int value, input string name);
        exp_value.push_back(value);
        exp_test.push_back(name);
    endtask

    task send_idle(input int half, input int windows);
        int n;
        for (n = 0; n < windows; n++)
        begin
            queue_symbol(half);
        end
    endtask

    // bad_bit 0..7 replaces that data bit and ends the frame, 8 replaces the stop bit
    task send_frame(input logic [7:0] data, input int bad_bit, input int bad_half,
                    input string name);
        int b;
        int stop_half;
        queue_symbol(`FSK_F0_HALF);     // start
        for (b = 0; b < 8; b++)
        begin
            if (b == bad_bit)
            begin
                queue_symbol(bad_half);
                add_expected(-1, name);
                return;
            end
            queue_symbol(data[b] ? `FSK_F1_HALF : `FSK_F0_HALF);
        end
        stop_half = (bad_bit == 8) ? bad_half : `FSK_F1_HALF;
        queue_symbol(stop_half);
        add_expected((stop_half == `FSK_F1_HALF) ? int'(data) : -1, name);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitor, compared with the expected queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clock)
    begin
        if (rst_n && (byte_strobe || framing_error))
        begin
            // window_end sits in cycle k*BIT-1, strobes two cycles later
            if ((cycle_count % `FSK_BIT_CYCLES) != 1 || cycle_count < `FSK_BIT_CYCLES)
            begin
                $display("strobe at cycle %0d is not 2 cycles after a window end",
                         cycle_count);
                error_count++;
            end
            got_value = framing_error ? -1 : int'(byte_data);
            if (exp_value.size() == 0)
            begin
                $display("unexpected %s at cycle %0d", event_text(got_value), cycle_count);
                error_count++;
            end
            else
            begin
                want_value = exp_value.pop_front();
                want_test  = exp_test.pop_front();
                if (got_value != want_value)
                begin
                    $display("CHECK FAILED %s: expected %s, actual %s", want_test,
                             event_text(want_value), event_text(got_value));
                    error_count++;
                end
            end
        end
    end

    initial
    begin
        clock         = 1'b0;
        rst_n         = 1'b0;
        seed          = 27;
        error_count   = 0;
        total_windows = 0;

        send_idle(0, 5);                                    // quiet after reset
        for (i = 0; i < 20; i++)
        begin
            send_frame(8'($random(seed)), -1, 0, "random_bytes");
            gap = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
            send_idle(`FSK_F1_HALF, gap);
        end
        send_frame(8'($random(seed)), 8, `FSK_F0_HALF, "space_stop_bit");
        send_idle(`FSK_F1_HALF, 2);
        send_frame(8'($random(seed)), -1, 0, "after_space_stop");
        send_idle(`FSK_F1_HALF, 2);
        send_frame(8'($random(seed)), 3, 0, "silent_data_bit");
        send_idle(`FSK_F1_HALF, 2);
        send_frame(8'($random(seed)), -1, 0, "after_silent_bit");
        send_idle(OOB_HALF, 3);
        send_frame(8'($random(seed)), 5, OOB_HALF, "out_of_band_bit");
        send_idle(OOB_HALF, 2);
        send_frame(8'($random(seed)), -1, 0, "after_out_of_band");
        send_idle(`FSK_F1_HALF, 2);

        repeat (10) @(posedge clock);
        rst_n <= 1'b1;

        while (exp_value.size() != 0)
        begin
            pending     = exp_value.size();
            wait_cycles = 0;
            while (exp_value.size() == pending && wait_cycles < WAIT_LIMIT)
            begin
                @(posedge clock);
                wait_cycles++;
            end
            if (exp_value.size() == pending)
            begin
                $display("timeout: no byte or framing error within 20 windows");
                error_count++;
                break;
            end
        end

        // let the trailing windows run out to catch stray strobes
        end_cycle   = (total_windows + 2) * `FSK_BIT_CYCLES;
        wait_cycles = 0;
        while (cycle_count < end_cycle && wait_cycles < WAIT_LIMIT)
        begin
            @(posedge clock);
            wait_cycles++;
        end
        if (cycle_count < end_cycle)
        begin
            $display("timeout: tone sequence did not finish");
            error_count++;
        end

        $display("summary: %0d errors, %0d expected events not seen",
                 error_count, exp_value.size());
        if (error_count == 0 && exp_value.size() == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- fsk_demod.f
+incdir+rtl
rtl/fsk_pkg.sv
rtl/edge_sync.sv
rtl/tone_analyzer.sv
rtl/bit_slicer.sv
rtl/byte_deframer.sv
rtl/fsk_demod.sv
tb/fsk_tone_gen.sv
tb/tb_fsk_demod.sv

//--- run_sim.sh
#!/bin/sh
# build and run the FSK receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f fsk_demod.f \
    --top-module tb_fsk_demod -o tb_fsk_demod > build.log 2>&1 \
    && ./obj_dir/tb_fsk_demod > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
